// ==== all.f ====
design/commit_pkg.sv
design/wb_stage_reg.sv
design/commit_ctrl.sv
design/excp_decode.sv
design/regfile.sv
design/csr_excp_regs.sv
design/commit_top.sv
dv/commit_properties.sv
dv/tb_commit.sv

// ==== design/commit_ctrl.sv ====
`timescale 1ns/1ps
module commit_ctrl (
    input  commit_pkg::wb_lane_t            wb0_i,
    input  commit_pkg::wb_lane_t            wb1_i,
    input  logic [commit_pkg::reg_w-1:0]    era_i,
    input  logic                            dispatch_stallreq_i,
    input  logic [1:0]                      mem_stallreq_i,
    output logic [4:0]                      stall_o,
    output logic                            excp_flush_o,
    output logic                            ertn_flush_o,
    output logic                            flush_o,
    output logic [commit_pkg::reg_w-1:0]    redirect_pc_o,
    output commit_pkg::wb_reg_t             reg_w0_o,
    output commit_pkg::wb_reg_t             reg_w1_o,
    output commit_pkg::csr_write_t          csr_w0_o,
    output commit_pkg::csr_write_t          csr_w1_o,
    output commit_pkg::diff_commit_t        commit0_o,
    output commit_pkg::diff_commit_t        commit1_o,
    output logic [commit_pkg::excp_w-1:0]   excp_num_o,
    output logic [commit_pkg::reg_w-1:0]    excp_pc_o,
    output logic [commit_pkg::reg_w-1:0]    error_va_o,
    output logic                            valid_o
);

    logic lane0_ertn;
    logic lane0_sys;
    logic lane0_excp;
    logic lane1_ertn;
    logic lane1_excp;
    logic kill1;

    assign lane0_ertn = wb0_i.valid && (wb0_i.aluop == commit_pkg::op_ertn);
    assign lane0_sys  = wb0_i.valid && (wb0_i.aluop == commit_pkg::op_syscall);
    assign lane0_excp = wb0_i.valid && wb0_i.excp;

    // lane 1 is younger, anything that redirects in lane 0 squashes it
    assign kill1 = lane0_ertn || lane0_sys || lane0_excp;

    assign lane1_ertn = !kill1 && wb1_i.valid && (wb1_i.aluop == commit_pkg::op_ertn);
    assign lane1_excp = !kill1 && wb1_i.valid && wb1_i.excp;

    assign excp_flush_o = lane0_excp || lane1_excp;
    assign ertn_flush_o = !excp_flush_o && (lane0_ertn || lane1_ertn);
    assign flush_o      = excp_flush_o || ertn_flush_o;

    always_comb begin
        if (excp_flush_o) begin
            redirect_pc_o = commit_pkg::excp_entry;
        end else if (ertn_flush_o) begin
            redirect_pc_o = era_i;
        end else begin
            redirect_pc_o = '0;
        end
    end

    always_comb begin
        if (|mem_stallreq_i) begin
            stall_o = commit_pkg::stall_mem;
        end else if (dispatch_stallreq_i) begin
            stall_o = commit_pkg::stall_dispatch;
        end else begin
            stall_o = commit_pkg::stall_none;
        end
    end

    // an excepting lane retires nothing
    always_comb begin
        reg_w0_o     = wb0_i.wb_reg_o;
        reg_w0_o.we  = wb0_i.wb_reg_o.we && wb0_i.valid && !wb0_i.excp;
        csr_w0_o     = wb0_i.csr_signal_o;
        csr_w0_o.we  = wb0_i.csr_signal_o.we && wb0_i.valid && !wb0_i.excp;
        commit0_o    = wb0_i.valid ? wb0_i.diff_commit_o : '0;

        reg_w1_o     = wb1_i.wb_reg_o;
        reg_w1_o.we  = wb1_i.wb_reg_o.we && wb1_i.valid && !wb1_i.excp;
        csr_w1_o     = wb1_i.csr_signal_o;
        csr_w1_o.we  = wb1_i.csr_signal_o.we && wb1_i.valid && !wb1_i.excp;
        commit1_o    = wb1_i.valid ? wb1_i.diff_commit_o : '0;
        if (kill1) begin
            reg_w1_o  = '0;
            csr_w1_o  = '0;
            commit1_o = '0;
        end
    end

    // lane 0 first, wdata carries the faulting address
    always_comb begin
        if (lane0_excp) begin
            excp_num_o = wb0_i.excp_num;
            excp_pc_o  = wb0_i.wb_reg_o.pc;
            error_va_o = wb0_i.wb_reg_o.wdata;
        end else if (lane1_excp) begin
            excp_num_o = wb1_i.excp_num;
            excp_pc_o  = wb1_i.wb_reg_o.pc;
            error_va_o = wb1_i.wb_reg_o.wdata;
        end else begin
            excp_num_o = '0;
            excp_pc_o  = '0;
            error_va_o = '0;
        end
    end

    assign valid_o = wb0_i.valid || wb1_i.valid;

endmodule

// ==== design/commit_pkg.sv ====
package commit_pkg;

    localparam int unsigned reg_w   = 32;
    localparam int unsigned aluop_w = 8;
    localparam int unsigned excp_w  = 16;

    // ops the commit stage looks at
    localparam logic [aluop_w-1:0] op_syscall = 8'h45;
    localparam logic [aluop_w-1:0] op_ertn    = 8'h46;

    localparam logic [5:0] ecode_int  = 6'h00;
    localparam logic [5:0] ecode_pil  = 6'h01;
    localparam logic [5:0] ecode_pis  = 6'h02;
    localparam logic [5:0] ecode_pif  = 6'h03;
    localparam logic [5:0] ecode_pme  = 6'h04;
    localparam logic [5:0] ecode_ppi  = 6'h07;
    localparam logic [5:0] ecode_ade  = 6'h08;
    localparam logic [5:0] ecode_ale  = 6'h09;
    localparam logic [5:0] ecode_sys  = 6'h0b;
    localparam logic [5:0] ecode_brk  = 6'h0c;
    localparam logic [5:0] ecode_ine  = 6'h0d;
    localparam logic [5:0] ecode_ipe  = 6'h0e;
    localparam logic [5:0] ecode_tlbr = 6'h3f;

    localparam logic [8:0] esubcode_adef = 9'd0;
    localparam logic [8:0] esubcode_adem = 9'd1;

    // cause classes, one bit per exception vector position
    localparam logic [excp_w-1:0] addr_cause_mask   = 16'b1111_1110_0001_1110;
    localparam logic [excp_w-1:0] tlb_cause_mask    = 16'b1111_1000_0001_1100;
    localparam logic [excp_w-1:0] refill_cause_mask = 16'b0000_1000_0000_0100;
    localparam logic [excp_w-1:0] fetch_cause_mask  = 16'b0000_0000_0001_1110;

    localparam logic [reg_w-1:0] excp_entry = 32'h1c00_0000;

    localparam logic [4:0] stall_mem      = 5'b11110;
    localparam logic [4:0] stall_dispatch = 5'b11100;
    localparam logic [4:0] stall_none     = 5'b00000;

    typedef struct packed {
        logic             we;
        logic [4:0]       waddr;
        logic [reg_w-1:0] wdata;
        logic [reg_w-1:0] pc;
    } wb_reg_t;

    typedef struct packed {
        logic             we;
        logic [13:0]      addr;
        logic [reg_w-1:0] data;
    } csr_write_t;

    typedef struct packed {
        logic             valid;
        logic [reg_w-1:0] pc;
        logic [reg_w-1:0] inst;
    } diff_commit_t;

    typedef struct packed {
        logic               valid;
        logic [aluop_w-1:0] aluop;
        logic               excp;
        logic [excp_w-1:0]  excp_num;
        wb_reg_t            wb_reg_o;
        csr_write_t         csr_signal_o;
        diff_commit_t       diff_commit_o;
    } wb_lane_t;

    typedef struct packed {
        logic [5:0]       ecode;
        logic [8:0]       esubcode;
        logic             va_error;
        logic [reg_w-1:0] bad_va;
        logic             tlbrefill;
        logic             tlb;
        logic [18:0]      tlb_vppn;
    } excp_info_t;

endpackage

// ==== design/commit_top.sv ====
`timescale 1ns/1ps
module commit_top (
    input  logic                         clk,
    input  logic                         rst,
    input  commit_pkg::wb_lane_t         lane0_i,
    input  commit_pkg::wb_lane_t         lane1_i,
    input  logic                         dispatch_stallreq_i,
    input  logic [1:0]                   mem_stallreq_i,
    input  logic [4:0]                   raddr0_i,
    input  logic [4:0]                   raddr1_i,
    output logic [commit_pkg::reg_w-1:0] rdata0_o,
    output logic [commit_pkg::reg_w-1:0] rdata1_o,
    output logic [4:0]                   stall_o,
    output logic                         flush_o,
    output logic [commit_pkg::reg_w-1:0] redirect_pc_o,
    output commit_pkg::diff_commit_t     commit0_o,
    output commit_pkg::diff_commit_t     commit1_o,
    output commit_pkg::csr_write_t       csr_w0_o,
    output commit_pkg::csr_write_t       csr_w1_o,
    output logic [commit_pkg::reg_w-1:0] era_o,
    output logic [5:0]                   ecode_o,
    output logic [8:0]                   esubcode_o,
    output logic [commit_pkg::reg_w-1:0] badv_o,
    output logic [18:0]                  tlbehi_vppn_o,
    output logic                         tlbrefill_o
);

    commit_pkg::wb_lane_t          wb0;
    commit_pkg::wb_lane_t          wb1;
    commit_pkg::wb_reg_t           reg_w0;
    commit_pkg::wb_reg_t           reg_w1;
    commit_pkg::excp_info_t        excp_info;
    logic [commit_pkg::excp_w-1:0] excp_num;
    logic [commit_pkg::reg_w-1:0]  excp_pc;
    logic [commit_pkg::reg_w-1:0]  error_va;
    logic                          excp_flush;
    logic                          excp_valid;

    wb_stage_reg u_wb_stage_reg (
        .clk     (clk),
        .rst     (rst),
        .lane0_i (lane0_i),
        .lane1_i (lane1_i),
        .flush_i (flush_o),
        .wb0_o   (wb0),
        .wb1_o   (wb1)
    );

    commit_ctrl u_commit_ctrl (
        .wb0_i               (wb0),
        .wb1_i               (wb1),
        .era_i               (era_o),
        .dispatch_stallreq_i (dispatch_stallreq_i),
        .mem_stallreq_i      (mem_stallreq_i),
        .stall_o             (stall_o),
        .excp_flush_o        (excp_flush),
        .ertn_flush_o        (),
        .flush_o             (flush_o),
        .redirect_pc_o       (redirect_pc_o),
        .reg_w0_o            (reg_w0),
        .reg_w1_o            (reg_w1),
        .csr_w0_o            (csr_w0_o),
        .csr_w1_o            (csr_w1_o),
        .commit0_o           (commit0_o),
        .commit1_o           (commit1_o),
        .excp_num_o          (excp_num),
        .excp_pc_o           (excp_pc),
        .error_va_o          (error_va),
        .valid_o             (excp_valid)
    );

    excp_decode u_excp_decode (
        .excp_num_i (excp_num),
        .pc_i       (excp_pc),
        .error_va_i (error_va),
        .valid_i    (excp_valid),
        .info_o     (excp_info)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .w0_i     (reg_w0),
        .w1_i     (reg_w1),
        .raddr0_i (raddr0_i),
        .raddr1_i (raddr1_i),
        .rdata0_o (rdata0_o),
        .rdata1_o (rdata1_o)
    );

    csr_excp_regs u_csr_excp_regs (
        .clk           (clk),
        .rst           (rst),
        .excp_i        (excp_flush),
        .pc_i          (excp_pc),
        .info_i        (excp_info),
        .era_o         (era_o),
        .ecode_o       (ecode_o),
        .esubcode_o    (esubcode_o),
        .badv_o        (badv_o),
        .tlbehi_vppn_o (tlbehi_vppn_o),
        .tlbrefill_o   (tlbrefill_o)
    );

endmodule

// ==== design/csr_excp_regs.sv ====
`timescale 1ns/1ps
module csr_excp_regs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         excp_i,
    input  logic [commit_pkg::reg_w-1:0] pc_i,
    input  commit_pkg::excp_info_t       info_i,
    output logic [commit_pkg::reg_w-1:0] era_o,
    output logic [5:0]                   ecode_o,
    output logic [8:0]                   esubcode_o,
    output logic [commit_pkg::reg_w-1:0] badv_o,
    output logic [18:0]                  tlbehi_vppn_o,
    output logic                         tlbrefill_o
);

    always_ff @(posedge clk) begin
        if (rst) begin
            era_o         <= '0;
            ecode_o       <= '0;
            esubcode_o    <= '0;
            badv_o        <= '0;
            tlbehi_vppn_o <= '0;
            tlbrefill_o   <= 1'b0;
        end else if (excp_i) begin
            era_o       <= pc_i;
            ecode_o     <= info_i.ecode;
            esubcode_o  <= info_i.esubcode;
            // refill flag stays until the next exception
            tlbrefill_o <= info_i.tlbrefill;
            if (info_i.va_error) begin
                badv_o <= info_i.bad_va;
            end
            if (info_i.tlb) begin
                tlbehi_vppn_o <= info_i.tlb_vppn;
            end
        end
    end

endmodule

// ==== design/excp_decode.sv ====
`timescale 1ns/1ps
module excp_decode (
    input  logic [commit_pkg::excp_w-1:0] excp_num_i,
    input  logic [commit_pkg::reg_w-1:0]  pc_i,
    input  logic [commit_pkg::reg_w-1:0]  error_va_i,
    input  logic                          valid_i,
    output commit_pkg::excp_info_t        info_o
);

    logic [commit_pkg::excp_w-1:0] first;
    logic [commit_pkg::reg_w-1:0]  va;
    logic                          addr_cause;
    logic                          tlb_cause;
    logic                          refill_cause;

    // isolate the lowest set bit, bit 0 wins
    assign first = excp_num_i & (~excp_num_i + 1'b1);

    assign addr_cause   = |(first & commit_pkg::addr_cause_mask);
    assign tlb_cause    = |(first & commit_pkg::tlb_cause_mask);
    assign refill_cause = |(first & commit_pkg::refill_cause_mask);

    // fetch side faults on pc, memory side on the data address
    assign va = |(first & commit_pkg::fetch_cause_mask) ? pc_i : error_va_i;

    always_comb begin
        info_o = '0;
        case (first)
            16'h0001: info_o.ecode = commit_pkg::ecode_int;
            16'h0002: begin
                info_o.ecode    = commit_pkg::ecode_ade;
                info_o.esubcode = commit_pkg::esubcode_adef;
            end
            16'h0004: info_o.ecode = commit_pkg::ecode_tlbr;
            16'h0008: info_o.ecode = commit_pkg::ecode_pif;
            16'h0010: info_o.ecode = commit_pkg::ecode_ppi;
            16'h0020: info_o.ecode = commit_pkg::ecode_sys;
            16'h0040: info_o.ecode = commit_pkg::ecode_brk;
            16'h0080: info_o.ecode = commit_pkg::ecode_ine;
            16'h0100: info_o.ecode = commit_pkg::ecode_ipe;
            16'h0200: info_o.ecode = commit_pkg::ecode_ale;
            16'h0400: begin
                info_o.ecode    = commit_pkg::ecode_ade;
                info_o.esubcode = commit_pkg::esubcode_adem;
            end
            16'h0800: info_o.ecode = commit_pkg::ecode_tlbr;
            16'h1000: info_o.ecode = commit_pkg::ecode_pme;
            16'h2000: info_o.ecode = commit_pkg::ecode_ppi;
            16'h4000: info_o.ecode = commit_pkg::ecode_pis;
            16'h8000: info_o.ecode = commit_pkg::ecode_pil;
            default:  info_o.ecode = '0;
        endcase
        info_o.va_error  = valid_i && addr_cause;
        info_o.bad_va    = addr_cause ? va : '0;
        info_o.tlb       = valid_i && tlb_cause;
        info_o.tlbrefill = valid_i && refill_cause;
        info_o.tlb_vppn  = tlb_cause ? va[31:13] : '0;
    end

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/1ps
module regfile (
    input  logic                         clk,
    input  logic                         rst,
    input  commit_pkg::wb_reg_t          w0_i,
    input  commit_pkg::wb_reg_t          w1_i,
    input  logic [4:0]                   raddr0_i,
    input  logic [4:0]                   raddr1_i,
    output logic [commit_pkg::reg_w-1:0] rdata0_o,
    output logic [commit_pkg::reg_w-1:0] rdata1_o
);

    logic [commit_pkg::reg_w-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (w0_i.we && (w0_i.waddr != 5'd0)) begin
                regs[w0_i.waddr] <= w0_i.wdata;
            end
            // younger lane goes last on a collision
            if (w1_i.we && (w1_i.waddr != 5'd0)) begin
                regs[w1_i.waddr] <= w1_i.wdata;
            end
        end
    end

    assign rdata0_o = (raddr0_i == 5'd0) ? '0 : regs[raddr0_i];
    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];

endmodule

// ==== design/wb_stage_reg.sv ====
`timescale 1ns/1ps
module wb_stage_reg (
    input  logic                 clk,
    input  logic                 rst,
    input  commit_pkg::wb_lane_t lane0_i,
    input  commit_pkg::wb_lane_t lane1_i,
    input  logic                 flush_i,
    output commit_pkg::wb_lane_t wb0_o,
    output commit_pkg::wb_lane_t wb1_o
);

    // drop every enable a lane carries, payload is don't care
    function automatic commit_pkg::wb_lane_t squash(input commit_pkg::wb_lane_t lane);
        commit_pkg::wb_lane_t q;
        q = lane;
        q.valid               = 1'b0;
        q.excp                = 1'b0;
        q.wb_reg_o.we         = 1'b0;
        q.csr_signal_o.we     = 1'b0;
        q.diff_commit_o.valid = 1'b0;
        return q;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wb0_o <= squash(lane0_i);
            wb1_o <= squash(lane1_i);
        end else begin
            wb0_o <= lane0_i;
            wb1_o <= lane1_i;
        end
    end

endmodule

// ==== dv/commit_properties.sv ====
`timescale 1ns/1ps
module commit_properties (
    input logic                      clk_i,
    input logic                      rst_i,
    input commit_pkg::wb_lane_t      wb0_i,
    input logic [4:0]                stall_i,
    input logic                      flush_i,
    input commit_pkg::wb_reg_t       reg_w1_i,
    input commit_pkg::diff_commit_t  commit1_i
);

    logic lane0_ertn;

    assign lane0_ertn = wb0_i.valid && (wb0_i.aluop == commit_pkg::op_ertn);

    // ertn in lane 0 leaves nothing for lane 1 to retire
    ertn_kills_lane1: assert property (@(posedge clk_i) disable iff (rst_i)
        lane0_ertn |-> (reg_w1_i == '0) && (commit1_i == '0))
        else $error("lane 1 retired beside a lane 0 ertn");

    stall_legal: assert property (@(posedge clk_i) disable iff (rst_i)
        (stall_i == commit_pkg::stall_mem) || (stall_i == commit_pkg::stall_dispatch)
            || (stall_i == commit_pkg::stall_none))
        else $error("stall vector holds an illegal pattern");

    // writeback register is empty right after reset
    flush_low_after_rst: assert property (@(posedge clk_i)
        rst_i |=> !flush_i)
        else $error("flush raised in the cycle after reset");

endmodule

// ==== dv/tb_commit.sv ====
`timescale 1ns/1ps
module tb_commit;

    // rough cycle budget of all tests together
    localparam int test_cycles = 100;
    localparam int margin_ns   = 200;

    logic                         clk;
    logic                         rst;
    commit_pkg::wb_lane_t         lane0;
    commit_pkg::wb_lane_t         lane1;
    logic                         dispatch_stallreq;
    logic [1:0]                   mem_stallreq;
    logic [4:0]                   raddr0;
    logic [4:0]                   raddr1;
    logic [31:0]                  rdata0;
    logic [31:0]                  rdata1;
    logic [4:0]                   stall;
    logic                         flush;
    logic [31:0]                  redirect_pc;
    commit_pkg::diff_commit_t     commit0;
    commit_pkg::diff_commit_t     commit1;
    commit_pkg::csr_write_t       csr_w0;
    commit_pkg::csr_write_t       csr_w1;
    logic [31:0]                  era;
    logic [5:0]                   ecode;
    logic [8:0]                   esubcode;
    logic [31:0]                  badv;
    logic [18:0]                  vppn;
    logic                         tlbrefill;

    logic [31:0] lfsr_state;
    logic [31:0] model [32];
    logic [31:0] exp_era;
    logic [5:0]  exp_ecode;
    logic [8:0]  exp_esub;
    logic [31:0] exp_badv;
    logic [18:0] exp_vppn;
    logic        exp_refill;
    int          errors;
    int          checks;

    commit_top dut0 (
        .clk                 (clk),
        .rst                 (rst),
        .lane0_i             (lane0),
        .lane1_i             (lane1),
        .dispatch_stallreq_i (dispatch_stallreq),
        .mem_stallreq_i      (mem_stallreq),
        .raddr0_i            (raddr0),
        .raddr1_i            (raddr1),
        .rdata0_o            (rdata0),
        .rdata1_o            (rdata1),
        .stall_o             (stall),
        .flush_o             (flush),
        .redirect_pc_o       (redirect_pc),
        .commit0_o           (commit0),
        .commit1_o           (commit1),
        .csr_w0_o            (csr_w0),
        .csr_w1_o            (csr_w1),
        .era_o               (era),
        .ecode_o             (ecode),
        .esubcode_o          (esubcode),
        .badv_o              (badv),
        .tlbehi_vppn_o       (vppn),
        .tlbrefill_o         (tlbrefill)
    );

    bind commit_ctrl commit_properties u_props (
        .clk_i     (tb_commit.clk),
        .rst_i     (tb_commit.rst),
        .wb0_i     (wb0_i),
        .stall_i   (stall_o),
        .flush_i   (flush_o),
        .reg_w1_i  (reg_w1_o),
        .commit1_i (commit1_o)
    );

    always #5 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'ha300_0000;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    function automatic logic [4:0] rand_addr();
        logic [4:0] a;
        a = 5'(rand_bits(5));
        if (a == 5'd0) begin
            a = 5'd1;
        end
        return a;
    endfunction

    task automatic compare(input string name, input logic [127:0] got,
                           input logic [127:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error %s: got 0x%0h, expected 0x%0h", name, got, want);
        end
    endtask

    function automatic commit_pkg::wb_lane_t make_lane(
        input logic [commit_pkg::aluop_w-1:0] aluop,
        input logic [commit_pkg::excp_w-1:0]  excp_num,
        input logic                           we,
        input logic [4:0]                     waddr,
        input logic [31:0]                    wdata,
        input logic [31:0]                    pc
    );
        commit_pkg::wb_lane_t l;
        l = '0;
        l.valid               = 1'b1;
        l.aluop               = aluop;
        l.excp                = |excp_num;
        l.excp_num            = excp_num;
        l.wb_reg_o.we         = we;
        l.wb_reg_o.waddr      = waddr;
        l.wb_reg_o.wdata      = wdata;
        l.wb_reg_o.pc         = pc;
        l.csr_signal_o.we     = 1'b1;
        l.csr_signal_o.addr   = 14'(rand_bits(14));
        l.csr_signal_o.data   = rand_bits(32);
        l.diff_commit_o.valid = 1'b1;
        l.diff_commit_o.pc    = pc;
        l.diff_commit_o.inst  = rand_bits(32);
        return l;
    endfunction

    function automatic logic [5:0] cause_code(input int idx);
        case (idx)
            0:       return commit_pkg::ecode_int;
            1:       return commit_pkg::ecode_ade;
            2:       return commit_pkg::ecode_tlbr;
            3:       return commit_pkg::ecode_pif;
            4:       return commit_pkg::ecode_ppi;
            5:       return commit_pkg::ecode_sys;
            6:       return commit_pkg::ecode_brk;
            7:       return commit_pkg::ecode_ine;
            8:       return commit_pkg::ecode_ipe;
            9:       return commit_pkg::ecode_ale;
            10:      return commit_pkg::ecode_ade;
            11:      return commit_pkg::ecode_tlbr;
            12:      return commit_pkg::ecode_pme;
            13:      return commit_pkg::ecode_ppi;
            14:      return commit_pkg::ecode_pis;
            default: return commit_pkg::ecode_pil;
        endcase
    endfunction

    function automatic void expect_exception(input logic [15:0] num, input logic [31:0] pc,
                                             input logic [31:0] va);
        int          idx;
        logic [31:0] addr;
        idx = 0;
        for (int k = 15; k >= 0; k--) begin
            if (num[k]) begin
                idx = k;
            end
        end
        exp_era    = pc;
        exp_ecode  = cause_code(idx);
        exp_esub   = (idx == 10) ? commit_pkg::esubcode_adem : commit_pkg::esubcode_adef;
        addr       = (idx >= 1 && idx <= 4) ? pc : va;
        exp_refill = (idx == 2) || (idx == 11);
        if ((idx >= 1 && idx <= 4) || idx >= 9) begin
            exp_badv = addr;
        end
        if ((idx >= 2 && idx <= 4) || idx >= 11) begin
            exp_vppn = addr[31:13];
        end
    endfunction

    // what a retired pair should leave behind in the registers and CSRs
    function automatic void update_model(input commit_pkg::wb_lane_t l0,
                                         input commit_pkg::wb_lane_t l1);
        logic kill;
        kill = l0.valid && (l0.excp || l0.aluop == commit_pkg::op_ertn
                            || l0.aluop == commit_pkg::op_syscall);
        if (l0.valid && !l0.excp && l0.wb_reg_o.we && l0.wb_reg_o.waddr != 5'd0) begin
            model[l0.wb_reg_o.waddr] = l0.wb_reg_o.wdata;
        end
        if (!kill && l1.valid && !l1.excp && l1.wb_reg_o.we && l1.wb_reg_o.waddr != 5'd0) begin
            model[l1.wb_reg_o.waddr] = l1.wb_reg_o.wdata;
        end
        if (l0.valid && l0.excp) begin
            expect_exception(l0.excp_num, l0.wb_reg_o.pc, l0.wb_reg_o.wdata);
        end else if (!kill && l1.valid && l1.excp) begin
            expect_exception(l1.excp_num, l1.wb_reg_o.pc, l1.wb_reg_o.wdata);
        end
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive(input commit_pkg::wb_lane_t l0, input commit_pkg::wb_lane_t l1);
        lane0 = l0;
        lane1 = l1;
    endtask

    // returns with the pair sitting in the writeback register
    task automatic present(input commit_pkg::wb_lane_t l0, input commit_pkg::wb_lane_t l1);
        drive(l0, l1);
        update_model(l0, l1);
        next_cycle();
        drive('0, '0);
    endtask

    task automatic step_and_check_regs(input logic [4:0] a, input logic [4:0] b);
        raddr0 = a;
        raddr1 = b;
        next_cycle();
        compare("rdata0_o", rdata0, model[a]);
        compare("rdata1_o", rdata1, model[b]);
    endtask

    task automatic check_csrs();
        compare("era_o", era, exp_era);
        compare("ecode_o", ecode, exp_ecode);
        compare("esubcode_o", esubcode, exp_esub);
        compare("badv_o", badv, exp_badv);
        compare("tlbehi_vppn_o", vppn, exp_vppn);
        compare("tlbrefill_o", tlbrefill, exp_refill);
    endtask

    task automatic test_reset();
        compare("stall_o", stall, 5'b00000);
        compare("flush_o", flush, 1'b0);
        check_csrs();
        for (int k = 0; k < 16; k++) begin
            step_and_check_regs(5'(2 * k), 5'(2 * k + 1));
        end
    endtask

    task automatic test_dual_retire();
        logic [4:0]           a;
        logic [4:0]           b;
        commit_pkg::wb_lane_t l0;
        commit_pkg::wb_lane_t l1;
        repeat (4) begin
            a = rand_addr();
            b = 5'((a % 5'd31) + 5'd1);
            l0 = make_lane(8'h01, '0, 1'b1, a, rand_bits(32), rand_bits(32));
            l1 = make_lane(8'h01, '0, 1'b1, b, rand_bits(32), rand_bits(32));
            present(l0, l1);
            compare("commit0_o", commit0, l0.diff_commit_o);
            compare("commit1_o", commit1, l1.diff_commit_o);
            compare("csr_w0_o", csr_w0, l0.csr_signal_o);
            compare("csr_w1_o", csr_w1, l1.csr_signal_o);
            step_and_check_regs(a, b);
        end
        // same address, the younger lane must win
        a = rand_addr();
        l0 = make_lane(8'h01, '0, 1'b1, a, rand_bits(32), rand_bits(32));
        l1 = make_lane(8'h01, '0, 1'b1, a, rand_bits(32), rand_bits(32));
        present(l0, l1);
        step_and_check_regs(a, a);
        compare("rdata0_o", rdata0, l1.wb_reg_o.wdata);
    endtask

    task automatic test_lane_gating();
        logic [4:0]           b;
        commit_pkg::wb_lane_t l0;
        commit_pkg::wb_lane_t l1;
        for (int c = 0; c < 3; c++) begin
            b = rand_addr();
            case (c)
                0:       l0 = make_lane(commit_pkg::op_syscall, '0, 1'b0, 5'd0, 0, rand_bits(32));
                1:       l0 = make_lane(commit_pkg::op_ertn, '0, 1'b0, 5'd0, 0, rand_bits(32));
                default: l0 = make_lane(8'h01, 16'h0080, 1'b0, 5'd0, 0, rand_bits(32));
            endcase
            l1 = make_lane(8'h01, '0, 1'b1, b, rand_bits(32), rand_bits(32));
            present(l0, l1);
            compare("commit1_o", commit1, '0);
            compare("csr_w1_o", csr_w1, '0);
            step_and_check_regs(b, b);
        end
    endtask

    task automatic test_excp_priority();
        logic [4:0]           a;
        commit_pkg::wb_lane_t l0;
        commit_pkg::wb_lane_t l1;
        l0 = make_lane(8'h01, 16'h0200, 1'b0, 5'd0, rand_bits(32), rand_bits(32));
        l1 = make_lane(8'h01, 16'h0400, 1'b0, 5'd0, rand_bits(32), rand_bits(32));
        present(l0, l1);
        next_cycle();
        check_csrs();
        compare("era_o", era, l0.wb_reg_o.pc);
        compare("badv_o", badv, l0.wb_reg_o.wdata);
        // only the younger lane excepts
        a = rand_addr();
        l0 = make_lane(8'h01, '0, 1'b1, a, rand_bits(32), rand_bits(32));
        l1 = make_lane(8'h01, 16'h0400, 1'b0, 5'd0, rand_bits(32), rand_bits(32));
        present(l0, l1);
        step_and_check_regs(a, a);
        check_csrs();
        compare("era_o", era, l1.wb_reg_o.pc);
        compare("badv_o", badv, l1.wb_reg_o.wdata);
    endtask

    task automatic test_cause_decode();
        logic [15:0]          bit_i;
        logic [15:0]          higher;
        logic [4:0]           r;
        commit_pkg::wb_lane_t l0;
        for (int i = 0; i < 16; i++) begin
            bit_i  = 16'h1 << i;
            higher = ~((bit_i << 1) - 16'h1);
            r      = rand_addr();
            l0 = make_lane(8'h01, bit_i | (16'(rand_bits(16)) & higher), 1'b1, r,
                           rand_bits(32), rand_bits(32));
            present(l0, '0);
            compare("flush_o", flush, 1'b1);
            step_and_check_regs(r, r);
            check_csrs();
        end
    endtask

    task automatic test_flush_redirect();
        commit_pkg::wb_lane_t l0;
        commit_pkg::wb_lane_t w0;
        commit_pkg::wb_lane_t w1;
        for (int c = 0; c < 2; c++) begin
            if (c == 0) begin
                l0 = make_lane(8'h01, 16'h0040, 1'b0, 5'd0, 0, rand_bits(32));
            end else begin
                l0 = make_lane(commit_pkg::op_ertn, '0, 1'b0, 5'd0, 0, rand_bits(32));
            end
            w0 = make_lane(8'h01, '0, 1'b1, 5'd3, rand_bits(32), rand_bits(32));
            w1 = make_lane(8'h01, '0, 1'b1, 5'd4, rand_bits(32), rand_bits(32));
            present(l0, '0);
            compare("flush_o", flush, 1'b1);
            if (c == 0) begin
                compare("redirect_pc_o", redirect_pc, 32'h1c00_0000);
            end else begin
                compare("redirect_pc_o", redirect_pc, exp_era);
            end
            // this pair arrives while flushing and must vanish
            drive(w0, w1);
            next_cycle();
            drive('0, '0);
            compare("flush_o", flush, 1'b0);
            compare("commit0_o.valid", commit0.valid, 1'b0);
            step_and_check_regs(5'd3, 5'd4);
        end
    endtask

    task automatic test_stall();
        logic [4:0] want;
        for (int k = 0; k < 8; k++) begin
            dispatch_stallreq = k[2];
            mem_stallreq      = k[1:0];
            next_cycle();
            if (k[1:0] != 2'b00) begin
                want = 5'b11110;
            end else if (k[2]) begin
                want = 5'b11100;
            end else begin
                want = 5'b00000;
            end
            compare("stall_o", stall, want);
        end
        dispatch_stallreq = 1'b0;
        mem_stallreq      = 2'b00;
    endtask

    initial begin
        clk               = 1'b0;
        rst               = 1'b1;
        lane0             = '0;
        lane1             = '0;
        dispatch_stallreq = 1'b0;
        mem_stallreq      = 2'b00;
        raddr0            = 5'd0;
        raddr1            = 5'd0;
        lfsr_state        = 32'h137a;
        exp_era           = '0;
        exp_ecode         = '0;
        exp_esub          = '0;
        exp_badv          = '0;
        exp_vppn          = '0;
        exp_refill        = 1'b0;
        errors            = 0;
        checks            = 0;
        for (int k = 0; k < 32; k++) begin
            model[k] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_dual_retire();
        test_lane_gating();
        test_excp_priority();
        test_cause_decode();
        test_flush_redirect();
        test_stall();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(test_cycles * 10 + margin_ns);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the commit testbench with verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_commit \
        -o vtb_commit; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/vtb_commit > "$log" 2>&1; then
    cat "$log"
    echo "simulation exited with an error"
    exit 1
fi

cat "$log"

if grep -qx "TEST PASS" "$log"; then
    exit 0
fi
exit 1
